//--- include/spi_reg_params.svh
// Width, device id and sck timing macros for the SPI register master.

`ifndef SPI_REG_PARAMS_SVH
`define SPI_REG_PARAMS_SVH

// Register address width on the SPI side and on the Wishbone side.
`define REG_ADDR_W 8

// Register word width.
`define REG_DATA_W 16

// One frame is header byte, address byte and data word.
`define FRAME_W 32

// Slave device id. The read flag follows it as bit 0 of the header byte.
`define DEV_ID 7'h32

// mclk cycles in half an sck period.
`define SCK_HALF 8

`endif

//--- logic/spi_reg_pkg.sv
// Vector types and frame engine state encoding for the SPI register master.

`include "spi_reg_params.svh"

package spi_reg_pkg;

   // Register address as sent in the second frame byte.
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

   // Register word, written or read in the data phase.
   typedef logic [`REG_DATA_W-1:0] reg_data_t;

   // Complete frame, MSB goes out first.
   typedef logic [`FRAME_W-1:0] frame_t;

   typedef logic [$clog2(`SCK_HALF)-1:0] half_cnt_t;   // Counts within half an sck period.

   typedef logic [$clog2(`FRAME_W+1)-1:0] bit_cnt_t;   // Reaches FRAME_W at the end.

   // Select low, then the sck pulses, then the hold time before select rises.
   typedef enum logic [1:0] {
      st_idle,
      st_lead,
      st_shift,
      st_trail
   } engine_state_t;

endpackage

//--- logic/wb_cmd_decode.sv
// Wishbone cycle acceptance and frame word assembly for the SPI register master.

`timescale 1ns/10ps

`include "spi_reg_params.svh"

module wb_cmd_decode (
   input  logic                   mclk,
   input  logic                   reset,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  spi_reg_pkg::reg_addr_t wb_adr,
   input  spi_reg_pkg::reg_data_t wb_dat_w,
   input  logic                   wb_ack,
   output logic                   start,
   output spi_reg_pkg::frame_t    frame
);

   import spi_reg_pkg::*;

   logic      busy;
   logic      accept;
   logic      rd_flag;
   reg_data_t data_word;
   frame_t    next_frame;

   assign accept  = wb_cyc && wb_stb && !busy;
   assign rd_flag = ~wb_we;

   // A read shifts out zeros while the slave answers on miso.
   assign data_word  = wb_we ? wb_dat_w : reg_data_t'(0);
   assign next_frame = {`DEV_ID, rd_flag, wb_adr, data_word};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Cycle tracking
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge mclk or negedge reset)
   begin
      if (!reset)
      begin
         busy  <= 1'b0;
         start <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         if (accept)
         begin
            busy  <= 1'b1;
            start <= 1'b1;
         end
         else if (wb_ack)
         begin
            busy <= 1'b0;   // Host may open the next cycle from here on.
         end
      end
   end

   // The engine reads this for the whole frame.
   always_ff @(posedge mclk)
   begin
      if (accept)
         frame <= next_frame;
   end

   // The acknowledge may only close a cycle that was accepted here.
   a_ack_when_busy : assert property (
      @(posedge mclk) disable iff (!reset)
      wb_ack |-> busy
   );

endmodule

//--- logic/spi_frame_engine.sv
// Mode 0 SPI frame engine driving select, clock and data for one 32-bit frame.

`timescale 1ns/10ps

`include "spi_reg_params.svh"

module spi_frame_engine (
   input  logic                mclk,
   input  logic                reset,
   input  logic                start,
   input  spi_reg_pkg::frame_t frame,
   output logic                ss_n,
   output logic                sck,
   output logic                mosi,
   output logic                sample,
   output logic                frame_done
);

   import spi_reg_pkg::*;

   engine_state_t state;
   half_cnt_t     half_cnt;
   bit_cnt_t      bit_cnt;
   frame_t        shift_reg;
   logic          half_end;
   logic          sck_fall;
   logic          last_bit;

   assign half_end = (half_cnt == half_cnt_t'(`SCK_HALF - 1));
   assign sck_fall = (state == st_shift) && half_end && sck;
   assign last_bit = (bit_cnt == bit_cnt_t'(`FRAME_W - 1));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Frame sequencing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge mclk or negedge reset)
   begin
      if (!reset)
      begin
         state      <= st_idle;
         half_cnt   <= '0;
         bit_cnt    <= '0;
         ss_n       <= 1'b1;
         sck        <= 1'b0;
         mosi       <= 1'b1;
         sample     <= 1'b0;
         frame_done <= 1'b0;
      end
      else
      begin
         sample     <= 1'b0;
         frame_done <= 1'b0;
         half_cnt   <= half_end ? half_cnt_t'(0) : half_cnt + 1'b1;
         unique case (state)
            st_idle:
            begin
               half_cnt <= '0;
               if (start)
               begin
                  state   <= st_lead;
                  bit_cnt <= '0;
                  ss_n    <= 1'b0;
                  mosi    <= frame[`FRAME_W-1];   // First bit is set up with select.
               end
            end
            st_lead:
            begin
               if (half_end)
               begin
                  state  <= st_shift;
                  sck    <= 1'b1;
                  sample <= 1'b1;
               end
            end
            st_shift:
            begin
               if (half_end && !sck)
               begin
                  sck    <= 1'b1;
                  sample <= 1'b1;
               end
               else if (sck_fall)
               begin
                  sck     <= 1'b0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (last_bit)
                     state <= st_trail;   // Last data bit stays on mosi.
                  else
                     mosi <= shift_reg[`FRAME_W-2];
               end
            end
            st_trail:
            begin
               if (half_end)
               begin
                  state      <= st_idle;
                  ss_n       <= 1'b1;
                  mosi       <= 1'b1;
                  frame_done <= 1'b1;
               end
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // Bit 31 sits on mosi, so the register moves one step ahead of it.
   always_ff @(posedge mclk)
   begin
      if (state == st_idle && start)
         shift_reg <= frame;
      else if (sck_fall)
         shift_reg <= {shift_reg[`FRAME_W-2:0], 1'b0};
   end

   a_sck_idle_low : assert property (
      @(posedge mclk) disable iff (!reset)
      ss_n |-> !sck
   );

   // The slave samples on the rising edge and may look at mosi any time sck is high.
   a_mosi_stable_high : assert property (
      @(posedge mclk) disable iff (!reset)
      sck |-> $stable(mosi)
   );

endmodule

//--- logic/read_capture.sv
// miso capture and Wishbone acknowledge generation for the SPI register master.

`timescale 1ns/10ps

`include "spi_reg_params.svh"

module read_capture (
   input  logic                   mclk,
   input  logic                   reset,
   input  logic                   miso,
   input  logic                   sample,
   input  logic                   frame_done,
   output logic                   wb_ack,
   output spi_reg_pkg::reg_data_t wb_dat_r
);

   import spi_reg_pkg::*;

   reg_data_t rx_shift;

   // Header and address bits fall out the top, the data phase remains.
   always_ff @(posedge mclk)
   begin
      if (sample)
         rx_shift <= {rx_shift[`REG_DATA_W-2:0], miso};
   end

   // Nothing shifts between the last sample and the acknowledge.
   assign wb_dat_r = rx_shift;

   always_ff @(posedge mclk or negedge reset)
   begin
      if (!reset)
      begin
         wb_ack <= 1'b0;
      end
      else
      begin
         wb_ack <= frame_done;   // One cycle after select rises.
      end
   end

   // The engine must never end two frames back to back.
   a_ack_single : assert property (
      @(posedge mclk) disable iff (!reset)
      wb_ack |=> !wb_ack
   );

endmodule

//--- logic/spi_reg_master.sv
// SPI register access master with a Wishbone classic slave port.

`timescale 1ns/10ps

module spi_reg_master (
   input  logic                   mclk,
   input  logic                   reset,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  spi_reg_pkg::reg_addr_t wb_adr,
   input  spi_reg_pkg::reg_data_t wb_dat_w,
   output logic                   wb_ack,
   output spi_reg_pkg::reg_data_t wb_dat_r,
   output logic                   ss_n,
   output logic                   sck,
   output logic                   mosi,
   input  logic                   miso
);

   import spi_reg_pkg::*;

   logic   start;
   frame_t frame;
   logic   sample;
   logic   frame_done;

   wb_cmd_decode wb_cmd_decode_i (
      .mclk       (mclk),
      .reset      (reset),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_ack     (wb_ack),
      .start      (start),
      .frame      (frame)
   );

   spi_frame_engine spi_frame_engine_i (
      .mclk       (mclk),
      .reset      (reset),
      .start      (start),
      .frame      (frame),
      .ss_n       (ss_n),
      .sck        (sck),
      .mosi       (mosi),
      .sample     (sample),
      .frame_done (frame_done)
   );

   read_capture read_capture_i (
      .mclk       (mclk),
      .reset      (reset),
      .miso       (miso),
      .sample     (sample),
      .frame_done (frame_done),
      .wb_ack     (wb_ack),
      .wb_dat_r   (wb_dat_r)
   );

   // An acknowledge only answers a cycle that is still open.
   a_ack_in_cycle : assert property (
      @(posedge mclk) disable iff (!reset)
      wb_ack |-> (wb_cyc && wb_stb)
   );

endmodule

//--- test/spi_slave_model.sv
// Behavioral mode 0 SPI register slave with a 256-word register array.

`timescale 1ns/10ps

`include "spi_reg_params.svh"

module spi_slave_model (
   input  logic                ss_n,
   input  logic                sck,
   input  logic                mosi,
   output logic                miso,
   output spi_reg_pkg::frame_t rx_frame,
   output logic [5:0]          rx_bits
);

   import spi_reg_pkg::*;

   reg_data_t mem [0:255];
   reg_data_t tx_shift;

   // Each register starts with its address on top and the inverted address below.
   initial
   begin
      for (int a = 0; a < 256; a++)
         mem[a] = {8'(a), ~8'(a)};
      miso     = 1'b0;
      rx_frame = '0;
      rx_bits  = '0;
      tx_shift = '0;
   end

   // Select falls with sck low, so sck tells the two events apart.
   always @(negedge ss_n or posedge sck)
   begin
      if (!sck)
      begin
         rx_frame <= '0;
         rx_bits  <= '0;
      end
      else if (!ss_n)
      begin
         rx_frame <= {rx_frame[`FRAME_W-2:0], mosi};
         rx_bits  <= rx_bits + 1'b1;
      end
   end

   // After 16 bits the header sits in [15:8] and the address in [7:0].
   always @(negedge sck)
   begin
      if (!ss_n && rx_bits == 6'd16)
      begin
         if (rx_frame[15:9] == `DEV_ID && rx_frame[8])
            tx_shift = mem[rx_frame[7:0]];
         else
            tx_shift = '0;
         miso <= tx_shift[15];
         tx_shift = tx_shift << 1;
      end
      else if (!ss_n && rx_bits > 6'd16)
      begin
         miso <= tx_shift[15];
         tx_shift = tx_shift << 1;   // Data goes out MSB first.
      end
   end

   always @(posedge ss_n)
   begin
      if (rx_bits == 6'd32 && rx_frame[31:25] == `DEV_ID && !rx_frame[24])
         mem[rx_frame[23:16]] <= rx_frame[15:0];
   end

endmodule

//--- test/spi_reg_master_tb.sv
// Testbench top with clock, reset, Wishbone stimulus, slave model and assertion checks.

`timescale 1ns/10ps

module spi_reg_master_tb;

   import spi_reg_pkg::*;

   localparam int clk_half    = 50;
   localparam int drive_dly   = 5;
   localparam int ack_timeout = 2000;   // A frame takes well under 600 mclk cycles.

   logic        mclk = 1'b0;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   reg_addr_t   wb_adr;
   reg_data_t   wb_dat_w;
   logic        wb_ack;
   reg_data_t   wb_dat_r;
   logic        ss_n;
   logic        sck;
   logic        mosi;
   logic        miso;
   frame_t      rx_frame;
   logic [5:0]  rx_bits;
   logic [15:0] rx_hdr_adr;
   logic        ss_n_q;
   logic        frame_seen;
   reg_data_t   exp_data;
   reg_data_t   ref_mem [0:255];

   assign rx_hdr_adr = rx_frame[31:16];

   always #(clk_half) mclk = ~mclk;

   spi_reg_master spi_reg_master_i (.*);

   spi_slave_model spi_slave_model_i (.*);

   // Device id 7'h32 followed by the read bit.
   function automatic logic [7:0] expected_header(input logic we);
      return we ? 8'h64 : 8'h65;
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wishbone host
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic wb_access(input logic we, input reg_addr_t adr, input reg_data_t dat);
      int waited;
      int gap;
      begin
         waited   = 0;
         gap      = $urandom_range(3, 0);
         wb_we    = we;
         wb_adr   = adr;
         wb_dat_w = dat;
         wb_cyc   = 1'b1;
         wb_stb   = 1'b1;
         while (!wb_ack && waited < ack_timeout)
         begin
            @(posedge mclk);
            #(drive_dly);
            waited++;
         end
         if (!wb_ack)
            abort_run($sformatf("no wb_ack within %0d cycles at address %h", ack_timeout, adr));
         @(posedge mclk);   // This edge samples the acknowledge.
         #(drive_dly);
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
         repeat (gap + 1) @(posedge mclk);
         #(drive_dly);
      end
   endtask

   task automatic read_reg(input reg_addr_t adr);
      exp_data = ref_mem[adr];
      wb_access(1'b0, adr, '0);
   endtask

   task automatic write_reg(input reg_addr_t adr, input reg_data_t dat);
      ref_mem[adr] = dat;
      wb_access(1'b1, adr, dat);
   endtask

   // Marks the first frame of the open cycle.
   always @(posedge mclk or negedge reset)
   begin
      if (!reset)
      begin
         ss_n_q     <= 1'b1;
         frame_seen <= 1'b0;
      end
      else
      begin
         ss_n_q <= ss_n;
         if (!wb_cyc)
            frame_seen <= 1'b0;
         else if (ss_n_q && !ss_n)
            frame_seen <= 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   a_idle : assert property (@(posedge mclk) disable iff (!reset)
      !wb_cyc |-> (ss_n && !wb_ack)
   ) else abort_run("SPI select or wb_ack active outside a Wishbone cycle");

   a_sck_window : assert property (@(posedge mclk) disable iff (!reset)
      ss_n |-> !sck
   ) else abort_run("sck is high while the slave is not selected");

   a_one_frame : assert property (@(posedge mclk) disable iff (!reset)
      $fell(ss_n) |-> (wb_cyc && wb_stb && !frame_seen)
   ) else abort_run("SPI frame started outside a cycle or twice within one cycle");

   a_frame_bits : assert property (@(posedge mclk) disable iff (!reset)
      $rose(ss_n) |-> (rx_bits == 6'd32)
   ) else abort_run($sformatf("mismatch rx_bits: expected %h, got %h",
                              6'd32, $sampled(rx_bits)));

   a_frame_lead : assert property (@(posedge mclk) disable iff (!reset)
      $rose(ss_n) |-> (rx_hdr_adr == {expected_header(wb_we), wb_adr})
   ) else abort_run($sformatf("mismatch rx_frame header and address: expected %h, got %h",
                              {expected_header($sampled(wb_we)), $sampled(wb_adr)},
                              $sampled(rx_hdr_adr)));

   a_ack_pulse : assert property (@(posedge mclk) disable iff (!reset)
      wb_ack |-> (wb_cyc && wb_stb && frame_seen) ##1 !wb_ack
   ) else abort_run("wb_ack outside an open cycle, before its frame or longer than one cycle");

   a_read_data : assert property (@(posedge mclk) disable iff (!reset)
      (wb_ack && !wb_we) |-> (wb_dat_r == exp_data)
   ) else abort_run($sformatf("mismatch wb_dat_r: expected %h, got %h",
                              $sampled(exp_data), $sampled(wb_dat_r)));

   initial
   begin
      reg_addr_t adr;
      reg_data_t dat;
      void'($urandom(32'hcd943870));
      reset    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      exp_data = '0;
      for (int a = 0; a < 256; a++)
         ref_mem[a] = {8'(a), ~8'(a)};
      repeat (5) @(posedge mclk);
      #(drive_dly);
      reset = 1'b1;
      repeat (4) @(posedge mclk);   // Idle bus right after reset.
      #(drive_dly);
      for (int i = 0; i < 6; i++)
      begin
         adr = reg_addr_t'($urandom());
         read_reg(adr);
      end
      for (int i = 0; i < 12; i++)
      begin
         adr = reg_addr_t'($urandom());
         dat = reg_data_t'($urandom());
         write_reg(adr, dat);
         read_reg(adr);
      end
      repeat (4) @(posedge mclk);
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- sim.f
+incdir+include
logic/spi_reg_pkg.sv
logic/wb_cmd_decode.sv
logic/spi_frame_engine.sv
logic/read_capture.sv
logic/spi_reg_master.sv
test/spi_slave_model.sv
test/spi_reg_master_tb.sv
